// File: Bender.yml
package:
  name: wb_sched

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_bus_pkg.sv
      - hdl/wb_unit_pkg.sv
      - hdl/reservation_line.sv
      - hdl/gpr_cdb_arbiter.sv
      - hdl/fpr_cdb_arbiter.sv
      - hdl/operand_bypass.sv
      - hdl/wb_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/wb_tb.sv

// File: bench/wb_tb.sv
`include "wb_cfg.svh"

module wb_tb;

	localparam int RUN_LIMIT = 2000;

	logic clk;
	logic reset;
	wb_unit_pkg::gpr_req_vec_t gpr_req;
	wb_unit_pkg::gpr_ready_t   gpr_ready;
	wb_unit_pkg::fpr_req_vec_t fpr_req;
	wb_unit_pkg::fpr_ready_t   fpr_ready;
	wb_bus_pkg::cdb_t          gpr_cdb;
	wb_bus_pkg::cdb_t          fpr_cdb;
	wb_bus_pkg::cdb_t [1:0]    gpr_arch_read;
	wb_bus_pkg::cdb_t [1:0]    gpr_rob_read;
	wb_bus_pkg::cdb_t [1:0]    fpr_arch_read;
	wb_bus_pkg::cdb_t [1:0]    fpr_rob_read;
	wb_bus_pkg::cdb_t [1:0]    gpr_operand;
	wb_bus_pkg::cdb_t [1:0]    fpr_operand;

	// class 0 is gpr, class 1 is fpr
	wb_unit_pkg::wb_req_t req [2][7];
	wb_bus_pkg::cdb_t     arch [2][2];
	wb_bus_pkg::cdb_t     rob [2][2];
	// reserved stages as the testbench sees them
	wb_bus_pkg::cdb_t     stages [2][`WB_FPR_DEPTH];
	logic [6:0]           acc [2];

	logic [31:0] seed;
	int          cycles;
	int          value_errors;
	int          other_errors;

	wb_top uut (
		.clk,
		.reset,
		.gpr_req,
		.gpr_ready,
		.fpr_req,
		.fpr_ready,
		.gpr_cdb,
		.fpr_cdb,
		.gpr_arch_read,
		.gpr_rob_read,
		.fpr_arch_read,
		.fpr_rob_read,
		.gpr_operand,
		.fpr_operand
	);

	always #10 clk = ~clk;

	always_comb begin
		for (int u = 0; u <= wb_unit_pkg::GPR_IN; u++) begin
			gpr_req[u] = req[0][u];
		end
		for (int u = 0; u <= wb_unit_pkg::FPR_IN; u++) begin
			fpr_req[u] = req[1][u];
		end
		for (int i = 0; i < 2; i++) begin
			gpr_arch_read[i] = arch[0][i];
			gpr_rob_read[i]  = rob[0][i];
			fpr_arch_read[i] = arch[1][i];
			fpr_rob_read[i]  = rob[1][i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] rand16();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[30:15];
	endfunction

	function automatic int unit_count(int c);
		return c ? wb_unit_pkg::FPR_IN + 1 : wb_unit_pkg::GPR_IN + 1;
	endfunction

	function automatic int line_depth(int c);
		return c ? `WB_FPR_DEPTH : `WB_GPR_DEPTH;
	endfunction

	function automatic int latency(int c, int u);
		if (c == 0) begin
			case (u)
				wb_unit_pkg::GPR_FTOI: return `WB_LAT_FTOI;
				wb_unit_pkg::GPR_IN:   return 0;
				default:               return `WB_LAT_SHORT;
			endcase
		end
		case (u)
			wb_unit_pkg::FPR_FDIV: return `WB_LAT_FDIV;
			wb_unit_pkg::FPR_FADD: return `WB_LAT_FADD;
			wb_unit_pkg::FPR_FMUL: return `WB_LAT_FMUL;
			wb_unit_pkg::FPR_ITOF: return `WB_LAT_ITOF;
			wb_unit_pkg::FPR_IN:   return 0;
			default:               return `WB_LAT_SHORT;
		endcase
	endfunction

	// older reservation above the target wins, then enum order
	function automatic logic [6:0] ready_ref(int c);
		logic [6:0] r;
		int l;
		r = '0;
		for (int u = 0; u < unit_count(c); u++) begin
			l = latency(c, u);
			r[u] = 1'b1;
			if (l == 0) begin
				r[u] = !stages[c][0].valid;
			end else if (l < line_depth(c)) begin
				r[u] = !stages[c][l].valid;
			end
			for (int e = 0; e < u; e++) begin
				if (l > 0 && latency(c, e) == l && req[c][e].valid) begin
					r[u] = 1'b0;
				end
			end
		end
		return r;
	endfunction

	// in is the last unit of each class
	function automatic wb_bus_pkg::cdb_t cdb_ref(int c, logic [6:0] r);
		wb_bus_pkg::cdb_t b;
		int in_unit;
		in_unit = unit_count(c) - 1;
		if (stages[c][0].valid) begin
			return stages[c][0];
		end
		b.valid = r[in_unit] && req[c][in_unit].valid;
		b.tag   = req[c][in_unit].tag;
		b.data  = req[c][in_unit].data;
		return b;
	endfunction

	function automatic wb_bus_pkg::cdb_t operand_ref(wb_bus_pkg::cdb_t a, wb_bus_pkg::cdb_t r,
	                                                 wb_bus_pkg::cdb_t b);
		wb_bus_pkg::cdb_t o;
		logic hit;
		hit     = b.valid && b.tag == a.tag;
		o.valid = a.valid || r.valid || hit;
		o.tag   = a.tag;
		o.data  = a.valid ? a.data : (hit ? b.data : r.data);
		return o;
	endfunction

	function automatic logic [6:0] ready_vec(int c);
		return c ? fpr_ready : 7'(gpr_ready);
	endfunction

	function automatic wb_bus_pkg::cdb_t cdb_vec(int c);
		return c ? fpr_cdb : gpr_cdb;
	endfunction

	function automatic wb_bus_pkg::cdb_t operand_vec(int c, int i);
		return c ? fpr_operand[i] : gpr_operand[i];
	endfunction

	task automatic check_value(string what, logic [63:0] got, logic [63:0] want);
		if (got !== want) begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
			value_errors++;
		end
	endtask

	// grants of this edge go one stage below their latency
	task automatic advance_line(int c, logic [6:0] r);
		wb_bus_pkg::cdb_t ins [`WB_FPR_DEPTH];
		int l;
		for (int k = 0; k < `WB_FPR_DEPTH; k++) begin
			ins[k] = '0;
		end
		for (int u = 0; u < unit_count(c); u++) begin
			acc[c][u] = r[u] && req[c][u].valid;
			l = latency(c, u);
			if (acc[c][u] && l > 0) begin
				ins[l-1] = '{1'b1, req[c][u].tag, req[c][u].data};
			end
		end
		for (int k = 0; k < line_depth(c); k++) begin
			stages[c][k] = ins[k];
			if (k + 1 < line_depth(c)) begin
				if (stages[c][k+1].valid) begin
					stages[c][k] = stages[c][k+1];
				end
			end
		end
	endtask

	always @(posedge clk) begin
		logic [6:0] want_ready;
		wb_bus_pkg::cdb_t want_cdb;
		wb_bus_pkg::cdb_t got_cdb;
		string cls;
		if (reset) begin
			for (int c = 0; c < 2; c++) begin
				for (int k = 0; k < `WB_FPR_DEPTH; k++) begin
					stages[c][k] = '0;
				end
				acc[c] = '0;
			end
		end else begin
			for (int c = 0; c < 2; c++) begin
				cls        = c ? "fpr" : "gpr";
				want_ready = ready_ref(c);
				want_cdb   = cdb_ref(c, want_ready);
				got_cdb    = cdb_vec(c);
				check_value({cls, " ready"}, ready_vec(c), want_ready);
				check_value({cls, " cdb valid"}, got_cdb.valid, want_cdb.valid);
				if (want_cdb.valid) begin
					check_value({cls, " cdb"}, got_cdb, want_cdb);
				end
				for (int i = 0; i < 2; i++) begin
					check_value({cls, " operand"}, operand_vec(c, i),
					            operand_ref(arch[c][i], rob[c][i], want_cdb));
				end
				advance_line(c, want_ready);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic wait_accept(int c, int u);
		logic [6:0] r;
		int n;
		n = 0;
		do begin
			@(posedge clk);
			r = ready_vec(c);
			n++;
		end while (!r[u] && n < 20);
		if (!r[u]) begin
			$display("unit %0d of class %0d was never accepted", u, c);
			other_errors++;
		end
	endtask

	task automatic latency_alone(int c, int u, wb_bus_pkg::tag_t t);
		wb_bus_pkg::cdb_t b;
		wb_bus_pkg::word_t d;
		int n;
		d = {rand16(), rand16()};
		@(negedge clk);
		req[c][u] = '{1'b1, t, d};
		wait_accept(c, u);
		n = 0;
		b = cdb_vec(c);
		while (!(b.valid && b.tag == t) && n < 20) begin
			@(negedge clk);
			req[c][u].valid = 1'b0;
			@(posedge clk);
			n++;
			b = cdb_vec(c);
		end
		@(negedge clk);
		req[c][u].valid = 1'b0;
		if (n == 20) begin
			$display("result of unit %0d of class %0d never reached the bus", u, c);
			other_errors++;
		end else begin
			check_value("latency", n, latency(c, u));
			check_value("result data", b.data, d);
		end
	endtask

	task automatic shared_stage();
		logic [6:0] r;
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_LW]      = '{1'b1, 6'd20, 32'h1111_0000};
		req[0][wb_unit_pkg::GPR_ADD_SUB] = '{1'b1, 6'd21, 32'h2222_0000};
		@(posedge clk);
		r = ready_vec(0);
		check_value("lw ready", r[wb_unit_pkg::GPR_LW], 1);
		check_value("add_sub ready", r[wb_unit_pkg::GPR_ADD_SUB], 0);
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_LW].valid = 1'b0;
		@(posedge clk);
		r = ready_vec(0);
		check_value("add_sub ready", r[wb_unit_pkg::GPR_ADD_SUB], 1);
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_ADD_SUB].valid = 1'b0;
	endtask

	// fdiv sits at stage 6 seven edges after its accept
	task automatic long_short_overlap();
		logic [6:0] r;
		wb_bus_pkg::cdb_t b;
		@(negedge clk);
		req[1][wb_unit_pkg::FPR_FDIV] = '{1'b1, 6'd30, 32'h3030_3030};
		wait_accept(1, wb_unit_pkg::FPR_FDIV);
		@(negedge clk);
		req[1][wb_unit_pkg::FPR_FDIV].valid = 1'b0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		req[1][wb_unit_pkg::FPR_FADD] = '{1'b1, 6'd31, 32'h3131_3131};
		@(posedge clk);
		r = ready_vec(1);
		check_value("fadd ready", r[wb_unit_pkg::FPR_FADD], 0);
		@(posedge clk);
		r = ready_vec(1);
		check_value("fadd ready", r[wb_unit_pkg::FPR_FADD], 1);
		@(negedge clk);
		req[1][wb_unit_pkg::FPR_FADD].valid = 1'b0;
		repeat (5) @(posedge clk);
		b = cdb_vec(1);
		check_value("fdiv result", {b.valid, b.tag}, {1'b1, 6'd30});
		@(posedge clk);
		b = cdb_vec(1);
		check_value("fadd result", {b.valid, b.tag}, {1'b1, 6'd31});
	endtask

	task automatic in_waits_for_head();
		logic [6:0] r;
		wb_bus_pkg::cdb_t b;
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_LW] = '{1'b1, 6'd40, 32'h4040_4040};
		wait_accept(0, wb_unit_pkg::GPR_LW);
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_LW].valid = 1'b0;
		req[0][wb_unit_pkg::GPR_IN] = '{1'b1, 6'd41, 32'h4141_4141};
		@(posedge clk);
		r = ready_vec(0);
		b = cdb_vec(0);
		check_value("in ready", r[wb_unit_pkg::GPR_IN], 0);
		check_value("lw on bus", {b.valid, b.tag}, {1'b1, 6'd40});
		@(posedge clk);
		r = ready_vec(0);
		b = cdb_vec(0);
		check_value("in ready", r[wb_unit_pkg::GPR_IN], 1);
		check_value("in on bus", {b.valid, b.tag}, {1'b1, 6'd41});
		@(negedge clk);
		req[0][wb_unit_pkg::GPR_IN].valid = 1'b0;
	endtask

	// small tag range so that bus hits are frequent
	task automatic random_traffic(int n);
		repeat (n) begin
			@(negedge clk);
			for (int c = 0; c < 2; c++) begin
				for (int u = 0; u < unit_count(c); u++) begin
					if (!req[c][u].valid || acc[c][u]) begin
						req[c][u].valid = rand16() % 3 == 0;
						req[c][u].tag   = 6'(rand16() % 8);
						req[c][u].data  = {rand16(), rand16()};
					end
				end
				for (int i = 0; i < 2; i++) begin
					arch[c][i].valid = rand16() % 2 == 1;
					arch[c][i].tag   = 6'(rand16() % 8);
					arch[c][i].data  = {rand16(), rand16()};
					rob[c][i].valid  = rand16() % 2 == 1;
					rob[c][i].tag    = 6'(rand16() % 8);
					rob[c][i].data   = {rand16(), rand16()};
				end
			end
		end
		@(negedge clk);
		for (int c = 0; c < 2; c++) begin
			for (int u = 0; u < 7; u++) begin
				req[c][u] = '0;
			end
		end
	endtask

	task automatic report();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors != 0) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles == RUN_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
			other_errors++;
			report();
		end
	end

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		seed         = 32'd60;
		cycles       = 0;
		value_errors = 0;
		other_errors = 0;
		for (int c = 0; c < 2; c++) begin
			for (int u = 0; u < 7; u++) begin
				req[c][u] = '0;
			end
			for (int i = 0; i < 2; i++) begin
				arch[c][i] = '0;
				rob[c][i]  = '0;
			end
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		check_value("gpr ready after reset", ready_vec(0), 7'h1f);
		check_value("fpr ready after reset", ready_vec(1), 7'h7f);
		check_value("gpr cdb after reset", gpr_cdb.valid, 0);
		check_value("fpr cdb after reset", fpr_cdb.valid, 0);
		for (int c = 0; c < 2; c++) begin
			for (int u = 0; u < unit_count(c); u++) begin
				latency_alone(c, u, 6'(8 * c + u + 1));
			end
		end
		shared_stage();
		long_short_overlap();
		in_waits_for_head();
		random_traffic(400);
		// let the longest reservation drain
		repeat (`WB_LAT_FDIV + 2) @(posedge clk);
		report();
	end

endmodule

// File: hdl/fpr_cdb_arbiter.sv
`include "wb_cfg.svh"

module fpr_cdb_arbiter (
	input  logic                      clk,
	input  logic                      reset,
	input  wb_unit_pkg::fpr_req_vec_t req,
	output wb_unit_pkg::fpr_ready_t   ready,
	output wb_bus_pkg::cdb_t          cdb
);

	wb_unit_pkg::fpr_ready_t valid;
	wb_unit_pkg::fpr_ready_t grant;

	wb_bus_pkg::cdb_t [`WB_FPR_DEPTH-1:0] insert;
	logic [`WB_FPR_DEPTH-1:0]             blocked;
	wb_bus_pkg::cdb_t                     head;

	always_comb begin
		for (int u = 0; u <= wb_unit_pkg::FPR_IN; u++) begin
			valid[u] = req[u].valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ready and grant
	//////////////////////////////////////////////////////////////////////

	// each long unit owns its own stage
	always_comb begin
		ready[wb_unit_pkg::FPR_FDIV] = !blocked[`WB_LAT_FDIV-1];
		ready[wb_unit_pkg::FPR_FADD] = !blocked[`WB_LAT_FADD-1];
		ready[wb_unit_pkg::FPR_FMUL] = !blocked[`WB_LAT_FMUL-1];
		ready[wb_unit_pkg::FPR_ITOF] = !blocked[`WB_LAT_ITOF-1];
		// lw and fmov share stage 0
		ready[wb_unit_pkg::FPR_LW]   = !blocked[`WB_LAT_SHORT-1];
		ready[wb_unit_pkg::FPR_FMOV] = !blocked[`WB_LAT_SHORT-1] &&
		                               !valid[wb_unit_pkg::FPR_LW];
		ready[wb_unit_pkg::FPR_IN]   = !head.valid;
	end

	assign grant = ready & valid;

	always_comb begin
		insert = '0;
		insert[`WB_LAT_FDIV-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_FDIV],
		                                           grant[wb_unit_pkg::FPR_FDIV]);
		insert[`WB_LAT_FADD-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_FADD],
		                                           grant[wb_unit_pkg::FPR_FADD]);
		insert[`WB_LAT_FMUL-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_FMUL],
		                                           grant[wb_unit_pkg::FPR_FMUL]);
		insert[`WB_LAT_ITOF-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_ITOF],
		                                           grant[wb_unit_pkg::FPR_ITOF]);
		if (grant[wb_unit_pkg::FPR_LW]) begin
			insert[`WB_LAT_SHORT-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_LW], 1'b1);
		end else if (grant[wb_unit_pkg::FPR_FMOV]) begin
			insert[`WB_LAT_SHORT-1] = wb_unit_pkg::slot(req[wb_unit_pkg::FPR_FMOV], 1'b1);
		end
	end

	reservation_line #(
		.DEPTH(`WB_FPR_DEPTH)
	) u_line (
		.clk,
		.reset,
		.insert,
		.blocked,
		.head
	);

	//////////////////////////////////////////////////////////////////////
	// bus
	//////////////////////////////////////////////////////////////////////

	// reserved slot first, in takes the gaps
	assign cdb = head.valid ? head : wb_unit_pkg::slot(req[wb_unit_pkg::FPR_IN],
	                                                   grant[wb_unit_pkg::FPR_IN]);

	a_in_needs_free_head : assert property (
		@(posedge clk) disable iff (reset)
		grant[wb_unit_pkg::FPR_IN] |-> !head.valid
	);

endmodule

// File: hdl/gpr_cdb_arbiter.sv
`include "wb_cfg.svh"

module gpr_cdb_arbiter (
	input  logic                      clk,
	input  logic                      reset,
	input  wb_unit_pkg::gpr_req_vec_t req,
	output wb_unit_pkg::gpr_ready_t   ready,
	output wb_bus_pkg::cdb_t          cdb
);

	wb_unit_pkg::gpr_ready_t valid;
	wb_unit_pkg::gpr_ready_t grant;

	wb_bus_pkg::cdb_t [`WB_GPR_DEPTH-1:0] insert;
	logic [`WB_GPR_DEPTH-1:0]             blocked;
	wb_bus_pkg::cdb_t                     head;

	always_comb begin
		for (int u = 0; u <= wb_unit_pkg::GPR_IN; u++) begin
			valid[u] = req[u].valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ready and grant
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ready[wb_unit_pkg::GPR_LW]       = !blocked[`WB_LAT_SHORT-1];
		ready[wb_unit_pkg::GPR_ADD_SUB]  = !blocked[`WB_LAT_SHORT-1] &&
		                                   !valid[wb_unit_pkg::GPR_LW];
		ready[wb_unit_pkg::GPR_NEXT_MOV] = !blocked[`WB_LAT_SHORT-1] &&
		                                   !valid[wb_unit_pkg::GPR_LW] &&
		                                   !valid[wb_unit_pkg::GPR_ADD_SUB];
		// top stage, never blocked
		ready[wb_unit_pkg::GPR_FTOI]     = !blocked[`WB_LAT_FTOI-1];
		// zero latency, needs a free head
		ready[wb_unit_pkg::GPR_IN]       = !head.valid;
	end

	assign grant = ready & valid;

	// reserve the slot at latency minus one
	always_comb begin
		insert = '0;
		insert[`WB_LAT_FTOI-1] = wb_unit_pkg::slot(req[wb_unit_pkg::GPR_FTOI],
		                                           grant[wb_unit_pkg::GPR_FTOI]);
		if (grant[wb_unit_pkg::GPR_LW]) begin
			insert[`WB_LAT_SHORT-1] = wb_unit_pkg::slot(req[wb_unit_pkg::GPR_LW], 1'b1);
		end else if (grant[wb_unit_pkg::GPR_ADD_SUB]) begin
			insert[`WB_LAT_SHORT-1] = wb_unit_pkg::slot(req[wb_unit_pkg::GPR_ADD_SUB], 1'b1);
		end else if (grant[wb_unit_pkg::GPR_NEXT_MOV]) begin
			insert[`WB_LAT_SHORT-1] = wb_unit_pkg::slot(req[wb_unit_pkg::GPR_NEXT_MOV], 1'b1);
		end
	end

	reservation_line #(
		.DEPTH(`WB_GPR_DEPTH)
	) u_line (
		.clk,
		.reset,
		.insert,
		.blocked,
		.head
	);

	// in only fills an empty head
	assign cdb = head.valid ? head : wb_unit_pkg::slot(req[wb_unit_pkg::GPR_IN],
	                                                   grant[wb_unit_pkg::GPR_IN]);

	a_one_grant_stage0 : assert property (
		@(posedge clk) disable iff (reset)
		$onehot0({grant[wb_unit_pkg::GPR_LW], grant[wb_unit_pkg::GPR_ADD_SUB],
		          grant[wb_unit_pkg::GPR_NEXT_MOV]})
	);

	// ftoi result reaches the bus after its full latency
	a_ftoi_latency : assert property (
		@(posedge clk) disable iff (reset)
		grant[wb_unit_pkg::GPR_FTOI] |-> ##`WB_LAT_FTOI
		(cdb.valid && cdb.tag == $past(req[wb_unit_pkg::GPR_FTOI].tag, `WB_LAT_FTOI))
	);

endmodule

// File: hdl/operand_bypass.sv
module operand_bypass (
	input  wb_bus_pkg::cdb_t arch,
	input  wb_bus_pkg::cdb_t rob,
	input  wb_bus_pkg::cdb_t cdb,
	output wb_bus_pkg::cdb_t operand
);

	logic cdb_hit;

	// result for the renamed source is on the bus right now
	assign cdb_hit = cdb.valid && cdb.tag == arch.tag;

	assign operand.valid = arch.valid || rob.valid || cdb_hit;
	// tag names the producer while the operand is pending
	assign operand.tag   = arch.tag;

	always_comb begin
		if (arch.valid) begin
			operand.data = arch.data;
		end else if (cdb_hit) begin
			operand.data = cdb.data;
		end else begin
			operand.data = rob.data;
		end
	end

endmodule

// File: hdl/reservation_line.sv
module reservation_line #(
	parameter int DEPTH = 3
) (
	input  logic                         clk,
	input  logic                         reset,
	input  wb_bus_pkg::cdb_t [DEPTH-1:0] insert,
	output logic [DEPTH-1:0]             blocked,
	output wb_bus_pkg::cdb_t             head
);

	wb_bus_pkg::cdb_t [DEPTH-1:0] stage;
	wb_bus_pkg::cdb_t [DEPTH-1:0] stage_next;

	//////////////////////////////////////////////////////////////////////
	// shift toward stage 0
	//////////////////////////////////////////////////////////////////////

	// older entry from above wins over a new insert
	always_comb begin
		for (int k = 0; k < DEPTH - 1; k++) begin
			blocked[k] = stage[k+1].valid;
			if (stage[k+1].valid) begin
				stage_next[k] = stage[k+1];
			end else begin
				stage_next[k] = insert[k];
			end
		end
		// nothing shifts into the top
		blocked[DEPTH-1]    = 1'b0;
		stage_next[DEPTH-1] = insert[DEPTH-1];
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < DEPTH; k++) begin
			stage[k].tag  <= stage_next[k].tag;
			stage[k].data <= stage_next[k].data;
			if (reset) begin
				stage[k].valid <= 1'b0;
			end else begin
				stage[k].valid <= stage_next[k].valid;
			end
		end
	end

	assign head = stage[0];

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// the arbiter's ready logic must keep inserts off occupied targets
	for (genvar k = 0; k < DEPTH; k++) begin : g_chk
		a_no_blocked_insert : assert property (
			@(posedge clk) disable iff (reset)
			!(insert[k].valid && blocked[k])
		);
	end

endmodule

// File: hdl/wb_bus_pkg.sv
`include "wb_cfg.svh"

package wb_bus_pkg;

	// reorder buffer entry number
	typedef logic [`WB_TAG_WIDTH-1:0] tag_t;

	typedef logic [`WB_WORD_WIDTH-1:0] word_t;

	// one bus beat
	// same shape for a reserved slot and for a read source
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} cdb_t;

endpackage

// File: hdl/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// rob tag and result word
`define WB_TAG_WIDTH 6
`define WB_WORD_WIDTH 32

// fixed latencies, accepting edge to bus
`define WB_LAT_FTOI 3
`define WB_LAT_FDIV 14
`define WB_LAT_FADD 6
`define WB_LAT_FMUL 4
`define WB_LAT_ITOF 3

// lw, add_sub, next_mov and fmov
`define WB_LAT_SHORT 1

// reservation line lengths
// each must cover the longest latency of its class
`define WB_GPR_DEPTH 3
`define WB_FPR_DEPTH 14

`endif

// File: hdl/wb_top.sv
module wb_top (
	input  logic                      clk,
	input  logic                      reset,

	input  wb_unit_pkg::gpr_req_vec_t gpr_req,
	output wb_unit_pkg::gpr_ready_t   gpr_ready,
	input  wb_unit_pkg::fpr_req_vec_t fpr_req,
	output wb_unit_pkg::fpr_ready_t   fpr_ready,

	output wb_bus_pkg::cdb_t          gpr_cdb,
	output wb_bus_pkg::cdb_t          fpr_cdb,

	input  wb_bus_pkg::cdb_t [1:0]    gpr_arch_read,
	input  wb_bus_pkg::cdb_t [1:0]    gpr_rob_read,
	input  wb_bus_pkg::cdb_t [1:0]    fpr_arch_read,
	input  wb_bus_pkg::cdb_t [1:0]    fpr_rob_read,

	output wb_bus_pkg::cdb_t [1:0]    gpr_operand,
	output wb_bus_pkg::cdb_t [1:0]    fpr_operand
);

	//////////////////////////////////////////////////////////////////////
	// write-back scheduling
	//////////////////////////////////////////////////////////////////////

	gpr_cdb_arbiter u_gpr_arb (
		.clk,
		.reset,
		.req   (gpr_req),
		.ready (gpr_ready),
		.cdb   (gpr_cdb)
	);

	fpr_cdb_arbiter u_fpr_arb (
		.clk,
		.reset,
		.req   (fpr_req),
		.ready (fpr_ready),
		.cdb   (fpr_cdb)
	);

	//////////////////////////////////////////////////////////////////////
	// operand read ports
	//////////////////////////////////////////////////////////////////////

	// two per class, each sees its own bus
	for (genvar i = 0; i < 2; i++) begin : g_gpr_read
		operand_bypass u_bypass (
			.arch    (gpr_arch_read[i]),
			.rob     (gpr_rob_read[i]),
			.cdb     (gpr_cdb),
			.operand (gpr_operand[i])
		);
	end

	for (genvar i = 0; i < 2; i++) begin : g_fpr_read
		operand_bypass u_bypass (
			.arch    (fpr_arch_read[i]),
			.rob     (fpr_rob_read[i]),
			.cdb     (fpr_cdb),
			.operand (fpr_operand[i])
		);
	end

endmodule

// File: hdl/wb_unit_pkg.sv
package wb_unit_pkg;

	// integer bus users, earlier wins at a shared stage
	typedef enum logic [2:0] {
		GPR_LW,
		GPR_ADD_SUB,
		GPR_NEXT_MOV,
		GPR_FTOI,
		GPR_IN
	} gpr_unit_e;

	// floating bus users, same ordering rule
	typedef enum logic [2:0] {
		FPR_FDIV,
		FPR_FADD,
		FPR_FMUL,
		FPR_ITOF,
		FPR_LW,
		FPR_FMOV,
		FPR_IN
	} fpr_unit_e;

	// result a unit wants scheduled
	typedef struct packed {
		logic              valid;
		wb_bus_pkg::tag_t  tag;
		wb_bus_pkg::word_t data;
	} wb_req_t;

	// indexed by the unit enums
	typedef wb_req_t [GPR_IN:0] gpr_req_vec_t;
	typedef logic [GPR_IN:0] gpr_ready_t;
	typedef wb_req_t [FPR_IN:0] fpr_req_vec_t;
	typedef logic [FPR_IN:0] fpr_ready_t;

	// bus slot for a request, valid only when granted
	function automatic wb_bus_pkg::cdb_t slot(wb_req_t r, logic grant);
		wb_bus_pkg::cdb_t s;
		s.valid = grant;
		s.tag   = r.tag;
		s.data  = r.data;
		return s;
	endfunction

endpackage

// File: verilog.f
+incdir+hdl
hdl/wb_bus_pkg.sv
hdl/wb_unit_pkg.sv
hdl/reservation_line.sv
hdl/gpr_cdb_arbiter.sv
hdl/fpr_cdb_arbiter.sv
hdl/operand_bypass.sv
hdl/wb_top.sv
bench/wb_tb.sv
